// ==== rtl/sensor_pkg.sv ====
// sensor sync subsystem shared constants, address map and command/status word types
package sensor_pkg;

    localparam int NUM_SENSORS = 4;                 // sensor channels
    localparam int CHN_SEL_W   = $clog2(NUM_SENSORS); // channel index width
    localparam int CMD_BYTES   = 6;                 // AL, AH, D0..D3
    localparam int CMD_ADDR_W  = 16;
    localparam int CMD_DATA_W  = 32;

    localparam logic [CMD_ADDR_W-1:0] SENSOR_GROUP_ADDR = 16'h0400; // subsystem base
    localparam logic [CMD_ADDR_W-1:0] SENSOR_BASE_INC   = 16'h0040; // per-channel stride
    localparam int SENSOR_OFFS_W = 6;               // offset bits inside one channel window

    // register offsets inside a channel window
    localparam logic [SENSOR_OFFS_W-1:0] SENSOR_CTRL_RADDR    = 6'h00; // mode register
    localparam logic [SENSOR_OFFS_W-1:0] SENS_SYNC_MULT_RADDR = 6'h06; // decimation count
    localparam logic [SENSOR_OFFS_W-1:0] SENS_SYNC_LATE_RADDR = 6'h07; // lines before sof_late
    localparam logic [SENSOR_OFFS_W-1:0] SENS_STATUS_RADDR    = 6'h08; // any write -> status

    localparam int SENS_SYNC_FBITS     = 16;        // decimation counter bits
    localparam int SENS_SYNC_LBITS     = 16;        // late line counter bits
    localparam int SENS_SYNC_LATE_DFLT = 15;        // late line count after reset
    localparam int FRAME_CNT_W         = 16;        // passed frame counter bits

    localparam int SENSIO_STATUS_REG_BASE = 'h20;   // status addresses 0x21, 0x23, ...
    localparam int SENSIO_STATUS_REG_INC  = 2;
    localparam int SENSIO_STATUS_REG_REL  = 1;
    localparam int STATUS_BYTES           = 5;      // address byte + 4 data bytes

    // mode view of a command data word
    typedef struct packed {
        logic [22:0] rsvd_hi;                       // reserved
        logic        chn_en;                        // bit 8, channel enable
        logic [7:0]  rsvd_lo;                       // reserved
    } sens_mode_t;

    // count view of a command data word
    typedef struct packed {
        logic [15:0] unused;
        logic [15:0] value;                         // decimation or line count
    } sens_count_t;

    // one data word, decoded by register offset
    typedef union packed {
        sens_mode_t  mode;                          // at SENSOR_CTRL_RADDR
        sens_count_t count;                         // at the sync offsets
    } sens_cmd_data_u;

    // status word sent after the address byte, lsb first
    typedef struct packed {
        logic [14:0]            zero;
        logic                   chn_en;             // bit 16
        logic [FRAME_CNT_W-1:0] frame_cnt;          // passed frames
    } sens_status_t;

endpackage

// ==== rtl/cmd_deser.sv ====
// command deserializer, six bytes of the byte-serial bus into one register write
`timescale 1ns/10ps

module cmd_deser import sensor_pkg::*; (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic [7:0]            cmd_ad,     // AL, AH, D0, D1, D2, D3
    input  logic                  cmd_stb,    // marks AL
    output logic [CMD_ADDR_W-1:0] wr_addr,
    output sens_cmd_data_u        wr_data,
    output logic                  wr_stb      // one cycle, with addr/data valid
);

    logic [2:0]                         byte_cnt; // 0 - idle, else index of next byte
    logic [CMD_ADDR_W+CMD_DATA_W-1:0]   cmd_sr;   // bytes shift in from the top

    // byte counter and write pulse
    always_ff @(posedge mclk) begin
        if (rst) begin
            byte_cnt <= 3'd0;
            wr_stb   <= 1'b0;
        end else begin
            wr_stb <= 1'b0;
            if (cmd_stb) begin
                byte_cnt <= 3'd1;                       // restarts any unfinished command
            end else if (byte_cnt == 3'(CMD_BYTES - 1)) begin
                byte_cnt <= 3'd0;                       // D3 taken now
                wr_stb   <= 1'b1;
            end else if (byte_cnt != 3'd0) begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end
    end

    // payload shift, lsb byte ends at the bottom
    always_ff @(posedge mclk) begin
        if (cmd_stb || (byte_cnt != 3'd0)) begin
            cmd_sr <= {cmd_ad, cmd_sr[CMD_ADDR_W+CMD_DATA_W-1:8]};
        end
    end

    assign wr_addr = cmd_sr[CMD_ADDR_W-1:0];            // AH:AL
    assign wr_data = cmd_sr[CMD_ADDR_W +: CMD_DATA_W];  // D3:D2:D1:D0

endmodule

// ==== rtl/sens_sync.sv ====
// frame sync for one sensor, decimation, delayed start of frame and passed frame count
`timescale 1ns/10ps

module sens_sync import sensor_pkg::*; (
    input  logic                       mclk,
    input  logic                       rst,
    input  logic                       chn_en,    // channel enable
    input  logic [SENS_SYNC_FBITS-1:0] mult,      // pass 1 of (mult+1) frames
    input  logic [SENS_SYNC_LBITS-1:0] late,      // lines before sof_late
    input  logic                       sof_in,
    input  logic                       eof_in,
    input  logic                       line_in,   // end of line
    output logic                       sof_out,
    output logic                       eof_out,
    output logic                       sof_late,
    output logic [FRAME_CNT_W-1:0]     frame_cnt  // frames passed so far
);

    logic [SENS_SYNC_FBITS-1:0] dec_cnt;   // input frame counter, wraps after mult
    logic [SENS_SYNC_LBITS-1:0] line_cnt;  // lines since accepted sof
    logic                       in_frame;  // between accepted sof and its eof
    logic                       late_pend; // sof_late still owed
    logic                       accept;    // this sof_in is passed

    assign accept = sof_in & chn_en & (dec_cnt == '0);

    always_ff @(posedge mclk) begin
        if (rst) begin
            dec_cnt   <= '0;
            line_cnt  <= '0;
            in_frame  <= 1'b0;
            late_pend <= 1'b0;
            sof_out   <= 1'b0;
            eof_out   <= 1'b0;
            sof_late  <= 1'b0;
            frame_cnt <= '0;
        end else begin
            sof_out  <= accept;
            eof_out  <= eof_in & in_frame;           // only the passed frame's eof
            sof_late <= 1'b0;

            // decimation
            if (!chn_en) begin
                dec_cnt <= '0;                       // disable restarts the sequence
            end else if (sof_in) begin
                dec_cnt <= (dec_cnt >= mult) ? '0 : dec_cnt + 1'b1;
            end

            if (accept) begin
                in_frame <= 1'b1;
            end else if (eof_in) begin
                in_frame <= 1'b0;
            end

            // late start, line count or eof, whichever first
            if (accept) begin
                line_cnt  <= '0;
                late_pend <= (late != '0);
                sof_late  <= (late == '0);           // zero lines - with sof_out
            end else if (late_pend && (eof_in || (line_in && (line_cnt + 1'b1 == late)))) begin
                late_pend <= 1'b0;
                sof_late  <= 1'b1;
            end else if (late_pend && line_in) begin
                line_cnt  <= line_cnt + 1'b1;
            end

            if (accept) begin
                frame_cnt <= frame_cnt + 1'b1;       // counts each sof_out
            end
        end
    end

endmodule

// ==== rtl/status_tx.sv ====
// status packet transmitter, address byte then the 32-bit status word lsb first
`timescale 1ns/10ps

module status_tx import sensor_pkg::*; #(
    parameter logic [7:0] STATUS_ADDR = 8'h21   // address byte of this source
) (
    input  logic         mclk,
    input  logic         rst,
    input  logic         send,          // request one packet
    input  sens_status_t status_word,
    output logic [7:0]   status_ad,
    output logic         status_rq,
    input  logic         status_start   // byte 0 goes out in this cycle
);

    logic                      rq_pend;   // request waiting for start
    logic [2:0]                byte_idx;  // 0 - idle, 1..4 data bytes
    logic [CMD_DATA_W-1:0]     word_sr;   // latched word, shifts down a byte per cycle

    assign status_rq = rq_pend & ~status_start;   // falls with the start pulse

    always_comb begin
        if (status_start) begin
            status_ad = STATUS_ADDR;              // byte 0
        end else if (byte_idx != 3'd0) begin
            status_ad = word_sr[7:0];
        end else begin
            status_ad = 8'h00;
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            rq_pend  <= 1'b0;
            byte_idx <= 3'd0;
        end else begin
            rq_pend <= send | (rq_pend & ~status_start); // new send keeps it pending
            if (status_start) begin
                byte_idx <= 3'd1;
            end else if (byte_idx == 3'(STATUS_BYTES - 1)) begin
                byte_idx <= 3'd0;                 // last data byte shown
            end else if (byte_idx != 3'd0) begin
                byte_idx <= byte_idx + 3'd1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (status_start) begin
            word_sr <= status_word;               // snapshot at start
        end else begin
            word_sr <= word_sr >> 8;
        end
    end

endmodule

// ==== rtl/sensor_channel.sv ====
// one sensor channel, register decode, frame sync and status source
`timescale 1ns/10ps

module sensor_channel import sensor_pkg::*; #(
    parameter int CHN_NUM = 0                       // channel index, sets addresses
) (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic [CMD_ADDR_W-1:0] wr_addr,          // broadcast write
    input  sens_cmd_data_u        wr_data,
    input  logic                  wr_stb,
    input  logic                  sof_in,
    input  logic                  eof_in,
    input  logic                  line_in,
    output logic                  sof_out,
    output logic                  eof_out,
    output logic                  sof_late,
    output logic [7:0]            status_ad,
    output logic                  status_rq,
    input  logic                  status_start
);

    logic [CMD_ADDR_W-1:0]      chn_base;   // first address of this window
    logic [SENSOR_OFFS_W-1:0]   reg_offs;   // register inside the window
    logic                       win_hit;    // write lands in this channel
    logic                       chn_en;
    logic [SENS_SYNC_FBITS-1:0] mult;
    logic [SENS_SYNC_LBITS-1:0] late;
    logic                       send;       // status request pulse
    logic [FRAME_CNT_W-1:0]     frame_cnt;
    sens_status_t               status_word;

    assign chn_base = SENSOR_GROUP_ADDR + CMD_ADDR_W'(CHN_NUM) * SENSOR_BASE_INC;
    assign reg_offs = wr_addr[SENSOR_OFFS_W-1:0];
    assign win_hit  = wr_stb &
        (wr_addr[CMD_ADDR_W-1:SENSOR_OFFS_W] == chn_base[CMD_ADDR_W-1:SENSOR_OFFS_W]);

    always_ff @(posedge mclk) begin
        if (rst) begin
            chn_en <= 1'b0;
            mult   <= '0;                           // every frame
            late   <= SENS_SYNC_LBITS'(SENS_SYNC_LATE_DFLT);
            send   <= 1'b0;
        end else begin
            send <= win_hit & (reg_offs == SENS_STATUS_RADDR); // data ignored
            if (win_hit) begin
                case (reg_offs)
                    SENSOR_CTRL_RADDR:    chn_en <= wr_data.mode.chn_en;  // mode view
                    SENS_SYNC_MULT_RADDR: mult   <= wr_data.count.value;  // count view
                    SENS_SYNC_LATE_RADDR: late   <= wr_data.count.value;
                    default: ;
                endcase
            end
        end
    end

    assign status_word = '{zero: '0, chn_en: chn_en, frame_cnt: frame_cnt};

    sens_sync sens_sync_i (
        .mclk      (mclk),
        .rst       (rst),
        .chn_en    (chn_en),
        .mult      (mult),
        .late      (late),
        .sof_in    (sof_in),
        .eof_in    (eof_in),
        .line_in   (line_in),
        .sof_out   (sof_out),
        .eof_out   (eof_out),
        .sof_late  (sof_late),
        .frame_cnt (frame_cnt)
    );

    status_tx #(
        .STATUS_ADDR (8'(SENSIO_STATUS_REG_BASE + SENSIO_STATUS_REG_REL +
                         CHN_NUM * SENSIO_STATUS_REG_INC))   // 0x21 + 2*chn
    ) status_tx_i (
        .mclk         (mclk),
        .rst          (rst),
        .send         (send),
        .status_word  (status_word),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

// ==== rtl/status_router4.sv ====
// round-robin status router, four packet sources onto one status byte bus
`timescale 1ns/10ps

module status_router4 import sensor_pkg::*; (
    input  logic                        mclk,
    input  logic                        rst,
    input  logic [NUM_SENSORS-1:0][7:0] db_in,     // per-source bytes
    input  logic [NUM_SENSORS-1:0]      rq_in,     // per-source requests
    output logic [NUM_SENSORS-1:0]      start_in,  // start to the selected source
    output logic [7:0]                  db_out,
    output logic                        rq_out,
    input  logic                        start_out  // consumer takes byte 0
);

    logic [CHN_SEL_W-1:0] sel;       // source on the bus
    logic [CHN_SEL_W-1:0] last;      // source served last
    logic [CHN_SEL_W-1:0] nxt;       // next requester after last
    logic [2:0]           busy_cnt;  // data bytes still to pass
    logic                 idle;

    assign idle = (busy_cnt == 3'd0);

    // search last+1 .. last+4, nearest wins
    always_comb begin
        logic [CHN_SEL_W-1:0] idx;
        nxt = sel;                                   // nobody asking - hold
        for (int k = NUM_SENSORS; k >= 1; k--) begin
            idx = last + CHN_SEL_W'(k);
            if (rq_in[idx]) begin
                nxt = idx;
            end
        end
    end

    always_comb begin
        start_in      = '0;
        start_in[sel] = start_out & idle;            // only one source sees start
    end

    assign rq_out = idle & rq_in[sel];               // hidden while a packet runs
    assign db_out = db_in[sel];                      // no delay

    always_ff @(posedge mclk) begin
        if (rst) begin
            sel      <= '0;
            last     <= '1;                          // channel 0 first
            busy_cnt <= 3'd0;
        end else if (idle && start_out) begin
            busy_cnt <= 3'(STATUS_BYTES - 1);        // sel frozen for the packet
            last     <= sel;
        end else if (!idle) begin
            busy_cnt <= busy_cnt - 3'd1;
        end else begin
            sel      <= nxt;
        end
    end

endmodule

// ==== rtl/sensors_sync4.sv ====
// four-channel sensor frame sync top with the command input stage, channels and status router
`timescale 1ns/10ps

module sensors_sync4 import sensor_pkg::*; (
    input  logic                   mclk,
    input  logic                   rst,
    input  logic [7:0]             cmd_ad,       // byte-serial command
    input  logic                   cmd_stb,      // with the first byte
    input  logic [NUM_SENSORS-1:0] sof_in,
    input  logic [NUM_SENSORS-1:0] eof_in,
    input  logic [NUM_SENSORS-1:0] line_in,
    output logic [NUM_SENSORS-1:0] sof_out,
    output logic [NUM_SENSORS-1:0] eof_out,
    output logic [NUM_SENSORS-1:0] sof_late,
    output logic [7:0]             status_ad,
    output logic                   status_rq,
    input  logic                   status_start
);

    logic [7:0]                  cmd_ad_r;     // registered command byte
    logic                        cmd_stb_r;
    logic [CMD_ADDR_W-1:0]       wr_addr;
    sens_cmd_data_u              wr_data;
    logic                        wr_stb;
    logic [NUM_SENSORS-1:0][7:0] status_ad_chn;
    logic [NUM_SENSORS-1:0]      status_rq_chn;
    logic [NUM_SENSORS-1:0]      status_start_chn;

    always_ff @(posedge mclk) begin
        if (rst) cmd_stb_r <= 1'b0;
        else     cmd_stb_r <= cmd_stb;
    end

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad;                          // command byte
    end

    cmd_deser cmd_deser_i (
        .mclk (mclk), .rst (rst),
        .cmd_ad (cmd_ad_r), .cmd_stb (cmd_stb_r),
        .wr_addr (wr_addr), .wr_data (wr_data), .wr_stb (wr_stb)
    );

    for (genvar i = 0; i < NUM_SENSORS; i++) begin : gen_chn
        sensor_channel #(.CHN_NUM (i)) sensor_channel_i (
            .mclk (mclk), .rst (rst),
            .wr_addr (wr_addr), .wr_data (wr_data), .wr_stb (wr_stb),   // broadcast
            .sof_in (sof_in[i]), .eof_in (eof_in[i]), .line_in (line_in[i]),
            .sof_out (sof_out[i]), .eof_out (eof_out[i]), .sof_late (sof_late[i]),
            .status_ad (status_ad_chn[i]), .status_rq (status_rq_chn[i]),
            .status_start (status_start_chn[i])
        );
    end

    status_router4 status_router4_i (
        .mclk (mclk), .rst (rst),
        .db_in (status_ad_chn), .rq_in (status_rq_chn), .start_in (status_start_chn),
        .db_out (status_ad), .rq_out (status_rq), .start_out (status_start)
    );

endmodule

// ==== tb/tb_ref_model.svh ====
// reference rules for the sensor sync testbench, decimation, late start and status packets
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// input frame n after enable passes when n is a multiple of count + 1
function automatic bit frame_passes(input int frame_idx, input int mult);
    return (frame_idx % (mult + 1)) == 0;
endfunction

// late sof due once enough lines seen, or at the frame's eof
function automatic bit late_due(input bit owed, input int late, input int lines, input bit eof);
    return owed && (eof || lines >= late);
endfunction

// status word, frame count low, enable at bit 16
function automatic logic [31:0] status_word(input int frame_cnt, input bit chn_en);
    return {15'd0, chn_en, frame_cnt[15:0]};
endfunction

function automatic logic [7:0] status_addr(input int chn);
    return 8'(8'h21 + 2 * chn);                  // 0x21, 0x23, 0x25, 0x27
endfunction

// channel window base plus register offset
function automatic logic [15:0] reg_addr(input int chn, input int offs);
    return 16'(16'h0400 + 16'h0040 * chn + offs);
endfunction

`endif

// ==== tb/tb_sensors_sync4.sv ====
// testbench for the four-channel sensor frame sync with its frame pulses and status packets
`timescale 1ns/10ps

module tb_sensors_sync4;

    localparam int CLK_PERIOD = 40;
    localparam int WAIT_LIMIT = 60;             // cycles any one wait may take

    logic       mclk;
    logic       rst;
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic [3:0] sof_in;
    logic [3:0] eof_in;
    logic [3:0] line_in;
    logic [3:0] sof_out;
    logic [3:0] eof_out;
    logic [3:0] sof_late;
    logic [7:0] status_ad;
    logic       status_rq;
    logic       status_start;

    int         seed;
    int         status_errors;
    int         frame_errors = 0;               // bumped by the compare process only
    int         en_m[4];                        // config as written to the DUT
    int         mult_m[4];
    int         late_m[4];
    int         frm_idx[4];                     // input frames since enable
    int         lines_seen[4];
    int         passed_cnt[4];                  // expected frame_cnt
    bit         passing[4];                     // current frame was passed
    bit         owed[4];                        // sof_late still due
    logic [3:0] exp_sof;
    logic [3:0] exp_eof;
    logic [3:0] exp_late;
    int         gen_wait[4];                    // random frame generator state
    int         gen_lines[4];
    bit         gen_open[4];

    `include "tb_ref_model.svh"

    sensors_sync4 dut_i (
        .mclk (mclk), .rst (rst), .cmd_ad (cmd_ad), .cmd_stb (cmd_stb),
        .sof_in (sof_in), .eof_in (eof_in), .line_in (line_in),
        .sof_out (sof_out), .eof_out (eof_out), .sof_late (sof_late),
        .status_ad (status_ad), .status_rq (status_rq), .status_start (status_start)
    );

    initial begin
        mclk = 1'b0;
        forever #(CLK_PERIOD / 2) mclk = ~mclk;
    end

    // expected pulses for the cycle after this edge
    always @(posedge mclk) begin
        exp_sof  = '0;
        exp_eof  = '0;
        exp_late = '0;
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                frm_idx[i]    = 0;
                passed_cnt[i] = 0;
                passing[i]    = 1'b0;
                owed[i]       = 1'b0;
            end else begin
                if (en_m[i] == 0) begin
                    frm_idx[i] = 0;             // disabled channel restarts decimation
                end else if (sof_in[i]) begin
                    if (frame_passes(frm_idx[i], mult_m[i])) begin
                        exp_sof[i] = 1'b1;
                        passing[i] = 1'b1;
                        passed_cnt[i]++;
                        lines_seen[i] = 0;
                        exp_late[i] = late_due(1'b1, late_m[i], 0, 1'b0); // late 0
                        owed[i] = !exp_late[i];
                    end
                    frm_idx[i]++;
                end
                if (eof_in[i]) begin
                    exp_eof[i]  = passing[i];
                    exp_late[i] = late_due(owed[i], late_m[i], lines_seen[i], 1'b1);
                    passing[i]  = 1'b0;
                    owed[i]     = 1'b0;
                end
                if (line_in[i] && owed[i]) begin
                    lines_seen[i]++;
                    exp_late[i] = late_due(1'b1, late_m[i], lines_seen[i], 1'b0);
                    owed[i] = !exp_late[i];
                end
            end
        end
    end

    // compare mid-cycle with outputs settled since the rising edge
    always @(negedge mclk) begin
        if (!rst) begin
            assert (sof_out === exp_sof) else begin
                frame_errors++;
                $display("ERROR %0t sof_out got %b expected %b", $time, sof_out, exp_sof);
            end
            assert (eof_out === exp_eof) else begin
                frame_errors++;
                $display("ERROR %0t eof_out got %b expected %b", $time, eof_out, exp_eof);
            end
            assert (sof_late === exp_late) else begin
                frame_errors++;
                $display("ERROR %0t sof_late got %b expected %b", $time, sof_late, exp_late);
            end
        end
    end

    task automatic abort_run(input string what);
        $display("timeout at %0t, %s never happened", $time, what);
        $display("frame errors %0d, status errors %0d", frame_errors, status_errors);
        $display("*** FAILED ***");
        $finish;
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // six command bytes then a wait for the broadcast write
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        logic [7:0] cmd_bytes[6];
        int         t;
        cmd_bytes = '{addr[7:0], addr[15:8], data[7:0], data[15:8], data[23:16], data[31:24]};
        for (int b = 0; b < 6; b++) begin
            @(negedge mclk);
            cmd_stb = (b == 0);                 // strobe marks the low address byte
            cmd_ad  = cmd_bytes[b];
        end
        @(negedge mclk);
        cmd_stb = 1'b0;
        cmd_ad  = 8'h00;
        t = 0;
        while (dut_i.wr_stb !== 1'b1) begin
            if (t == WAIT_LIMIT) abort_run("the register write strobe");
            @(negedge mclk);
            t++;
        end
        @(negedge mclk);                        // channel register loaded
    endtask

    // sof, nlines line pulses and eof with one idle cycle after each
    task automatic send_frame(input int ch, input int nlines);
        for (int k = 0; k < nlines + 2; k++) begin
            @(negedge mclk);
            if (k == 0) sof_in[ch] = 1'b1;
            else if (k <= nlines) line_in[ch] = 1'b1;
            else eof_in[ch] = 1'b1;
            @(negedge mclk);
            {sof_in, eof_in, line_in} = '0;
        end
    endtask

    // random frames on all channels until open frames finish
    task automatic run_traffic(input int cycles);
        int open_cnt;
        open_cnt = 0;
        for (int c = 0; c < cycles + WAIT_LIMIT; c++) begin
            @(negedge mclk);
            {sof_in, eof_in, line_in} = '0;
            open_cnt = 0;
            for (int i = 0; i < 4; i++) begin
                if (gen_wait[i] > 0) begin
                    gen_wait[i]--;
                end else if (!gen_open[i]) begin
                    if (c < cycles) begin       // no new frames in the tail
                        sof_in[i]    = 1'b1;
                        gen_open[i]  = 1'b1;
                        gen_lines[i] = rand_below(6);
                        gen_wait[i]  = 1 + rand_below(3);
                    end
                end else if (gen_lines[i] > 0) begin
                    line_in[i] = 1'b1;
                    gen_lines[i]--;
                    gen_wait[i] = rand_below(3);
                end else begin
                    eof_in[i]   = 1'b1;
                    gen_open[i] = 1'b0;
                    gen_wait[i] = 1 + rand_below(4);
                end
                if (gen_open[i]) open_cnt++;
            end
            if (c >= cycles && open_cnt == 0) break;
        end
        @(negedge mclk);
        {sof_in, eof_in, line_in} = '0;
        if (open_cnt != 0) abort_run("the close of the random frames");
    endtask

    // request status from the masked channels and check every packet
    task automatic read_status(input logic [3:0] mask);
        logic [7:0]  pkt[5];
        logic [3:0]  seen;
        logic [31:0] exp_word;
        int          n;
        int          t;
        int          ch;
        n    = 0;
        seen = '0;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                write_reg(reg_addr(i, 8), 32'h0);
                n++;
            end
        end
        for (int p = 0; p < n; p++) begin
            t = 0;
            while (status_rq !== 1'b1) begin
                if (t == WAIT_LIMIT) abort_run("a status request");
                @(negedge mclk);
                t++;
            end
            status_start = 1'b1;                // address byte shows this cycle
            #(CLK_PERIOD / 4) pkt[0] = status_ad;
            for (int b = 1; b < 5; b++) begin
                @(negedge mclk);
                status_start = 1'b0;
                #(CLK_PERIOD / 4) pkt[b] = status_ad;
            end
            ch = -1;
            for (int i = 0; i < 4; i++) begin
                if (mask[i] && !seen[i] && pkt[0] == status_addr(i)) ch = i;
            end
            assert (ch >= 0) else begin
                status_errors++;
                $display("ERROR %0t status_ad got %h expected the address of channel mask %b",
                         $time, pkt[0], mask & ~seen);
            end
            if (ch >= 0) begin
                seen[ch] = 1'b1;
                exp_word = status_word(passed_cnt[ch], en_m[ch] != 0);
                for (int b = 1; b < 5; b++) begin
                    assert (pkt[b] === exp_word[8*(b-1) +: 8]) else begin
                        status_errors++;
                        $display("ERROR %0t status_ad ch%0d byte %0d got %h expected %h",
                                 $time, ch, b, pkt[b], exp_word[8*(b-1) +: 8]);
                    end
                end
            end
            @(negedge mclk);
        end
        for (int k = 0; k < 10; k++) begin
            @(negedge mclk);
            assert (status_rq === 1'b0) else begin
                status_errors++;
                $display("ERROR %0t status_rq got %b expected 0 after %0d packets",
                         $time, status_rq, n);
            end
        end
    endtask

    initial begin
        seed = 3;
        status_errors = 0;
        rst = 1'b1;
        cmd_ad = 8'h00;
        cmd_stb = 1'b0;
        {sof_in, eof_in, line_in} = '0;
        status_start = 1'b0;
        for (int i = 0; i < 4; i++) begin
            en_m[i]   = 0;
            mult_m[i] = 0;
            late_m[i] = 15;                     // reset value of the late count
        end
        repeat (8) @(negedge mclk);
        rst = 1'b0;
        @(negedge mclk);
        assert (status_rq === 1'b0) else begin
            status_errors++;
            $display("ERROR %0t status_rq got %b expected 0", $time, status_rq);
        end
        read_status(4'b1111);                   // all zero after reset

        write_reg(reg_addr(1, 6), 32'd2);       // decimation passes frames 0, 3 and 6
        mult_m[1] = 2;
        write_reg(reg_addr(1, 0), 32'h100);
        en_m[1] = 1;
        repeat (9) send_frame(1, 2);
        read_status(4'b0010);

        write_reg(reg_addr(0, 7), 32'd3);       // late start after 3 lines
        late_m[0] = 3;
        write_reg(reg_addr(0, 0), 32'h100);
        en_m[0] = 1;
        send_frame(0, 5);
        send_frame(0, 2);                       // eof comes first

        for (int i = 0; i < 4; i++) begin
            write_reg(reg_addr(i, 0), 32'h0);
            en_m[i] = 0;
            mult_m[i] = rand_below(4);
            late_m[i] = rand_below(5);
            write_reg(reg_addr(i, 6), 32'(mult_m[i]));
            write_reg(reg_addr(i, 7), 32'(late_m[i]));
        end
        for (int i = 0; i < 4; i++) begin
            if (i != 2) begin                   // channel 2 stays off
                write_reg(reg_addr(i, 0), 32'h100);
                en_m[i] = 1;
            end
        end
        run_traffic(600);
        read_status(4'b1111);                   // four merged packets

        $display("frame errors %0d, status errors %0d", frame_errors, status_errors);
        if (frame_errors == 0 && status_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+tb
rtl/sensor_pkg.sv
rtl/cmd_deser.sv
rtl/sens_sync.sv
rtl/status_tx.sv
rtl/sensor_channel.sv
rtl/status_router4.sv
rtl/sensors_sync4.sv
tb/tb_sensors_sync4.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps -f filelist.f \
    --top-module tb_sensors_sync4 -o tb_sensors_sync4 || { echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/tb_sensors_sync4)
echo "$sim_out"
echo "$sim_out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
